/* hdl/fpu_macros.svh */
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

// binary32 field widths
`define FPU_EXP_BITS 8
`define FPU_MAN_BITS 23

// bookkeeping widths shared with the core
`define FPU_SQN_BITS 7
`define FPU_TAG_BITS 6

// quiet NaN with an empty payload
`define FPU_CANON_NAN 32'h7fc00000

`endif

/* hdl/fpuPkg.sv */
`include "fpu_macros.svh"

package fpuPkg;

    typedef logic [`FPU_EXP_BITS+`FPU_MAN_BITS:0] fpWord;
    typedef logic [`FPU_SQN_BITS-1:0] seqNum;
    typedef logic [`FPU_TAG_BITS-1:0] regTag;
    typedef logic [2:0] roundMode;

    typedef logic [`FPU_EXP_BITS-1:0] expField;
    typedef logic [`FPU_MAN_BITS-1:0] fracField;
    // significand with the hidden bit
    typedef logic [`FPU_MAN_BITS:0] sigField;
    // significand plus guard, round and sticky
    typedef logic [`FPU_MAN_BITS+3:0] sigGrs;
    // room for carry out and for exponents below one
    typedef logic signed [`FPU_EXP_BITS+1:0] wideExp;

    typedef enum logic [2:0] {FADD, FSUB, FEQ, FLT, FLE, FMIN, FMAX} fpuOpcode;

    typedef enum logic [2:0] {NONE, NX, UF, OF, DZ, NV, ILLEGAL} resultFlag;

    typedef struct packed {
        logic  taken;
        seqNum sqN;
    } branchProv;

    typedef struct packed {
        logic     valid;
        fpuOpcode opcode;
        fpWord    srcA;
        fpWord    srcB;
        seqNum    sqN;
        regTag    tagDst;
    } fpuUop;

    typedef struct packed {
        logic    sign;
        expField exp;
        sigField sig;
        logic    isZero;
        logic    isInf;
        logic    isQnan;
        logic    isSnan;
    } unpackedSrc;

    typedef struct packed {
        logic       valid;
        fpuOpcode   opcode;
        fpWord      srcA;
        fpWord      srcB;
        seqNum      sqN;
        regTag      tagDst;
        unpackedSrc a;
        unpackedSrc b;
        roundMode   rm;
        logic       illegal;
    } unpackedOp;

    typedef struct packed {
        logic     valid;
        fpuOpcode opcode;
        fpWord    srcA;
        fpWord    srcB;
        seqNum    sqN;
        regTag    tagDst;
        logic     sign;
        wideExp   exp;
        sigGrs    sig;
        logic     exactZero;
        logic     infResult;
        logic     nanResult;
        logic     invalid;
        logic     lessThan;
        logic     equal;
        logic     cmpInvalid;
        roundMode rm;
        logic     illegal;
    } alignedOp;

    typedef struct packed {
        logic      valid;
        fpWord     result;
        resultFlag flags;
        seqNum     sqN;
        regTag     tagDst;
    } fpuResult;

endpackage

/* hdl/fpuUnpackStage.sv */
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpuUnpackStage (
    input  logic              clk,
    input  logic              rstN,
    input  logic              en,
    input  fpuPkg::branchProv inBranch,
    input  fpuPkg::fpuUop     inUop,
    input  fpuPkg::roundMode  roundingMode,
    output fpuPkg::unpackedOp outOp
);
    import fpuPkg::*;

    function automatic unpackedSrc unpackSrc(input fpWord w);
        unpackedSrc u;
        expField e;
        fracField frac;
        logic expAllOnes;
        e = w[`FPU_EXP_BITS+`FPU_MAN_BITS-1:`FPU_MAN_BITS];
        frac = w[`FPU_MAN_BITS-1:0];
        expAllOnes = &e;
        u.sign = w[`FPU_EXP_BITS+`FPU_MAN_BITS];
        u.exp = e;
        // subnormals collapse to signed zero
        u.isZero = (e == '0);
        u.sig = u.isZero ? '0 : {1'b1, frac};
        u.isInf = expAllOnes && (frac == '0);
        u.isQnan = expAllOnes && frac[`FPU_MAN_BITS-1];
        u.isSnan = expAllOnes && !frac[`FPU_MAN_BITS-1] && (frac != '0);
        return u;
    endfunction

    logic younger;
    logic isArith;
    logic badMode;
    unpackedOp nextOp;

    // later in program order than the taken branch
    assign younger = inBranch.taken && ($signed(inUop.sqN - inBranch.sqN) > 0);

    assign isArith = (inUop.opcode == FADD) || (inUop.opcode == FSUB);

    // 5 and 6 are reserved encodings
    assign badMode = (roundingMode == 3'd5) || (roundingMode == 3'd6);

    always_comb begin
        nextOp.valid = inUop.valid && en && !younger;
        nextOp.opcode = inUop.opcode;
        nextOp.srcA = inUop.srcA;
        nextOp.srcB = inUop.srcB;
        nextOp.sqN = inUop.sqN;
        nextOp.tagDst = inUop.tagDst;
        nextOp.a = unpackSrc(inUop.srcA);
        nextOp.b = unpackSrc(inUop.srcB);
        nextOp.rm = roundingMode;
        nextOp.illegal = isArith && badMode;
    end

    always_ff @(posedge clk) begin
        outOp <= nextOp;
        if (!rstN) begin
            outOp.valid <= 1'b0;
        end
    end

    // nothing leaves this stage on the edge after reset
    assert property (@(posedge clk) !rstN |=> !outOp.valid);

endmodule

/* hdl/fpuAlignAddStage.sv */
`timescale 1ns/1ps

module fpuAlignAddStage (
    input  logic              clk,
    input  logic              rstN,
    input  fpuPkg::branchProv inBranch,
    input  fpuPkg::unpackedOp inOp,
    output fpuPkg::alignedOp  outOp
);
    import fpuPkg::*;

    function automatic logic [4:0] countLeadingZeros(input sigGrs v);
        logic [4:0] n;
        logic found;
        n = '0;
        found = 1'b0;
        for (int i = $bits(sigGrs) - 1; i >= 0; i--) begin
            if (!found && v[i]) begin
                found = 1'b1;
            end else if (!found) begin
                n = n + 5'd1;
            end
        end
        return n;
    endfunction

    logic younger;
    logic isArith;
    logic signB;
    logic [$bits(expField)+$bits(sigField)-1:0] magA;
    logic [$bits(expField)+$bits(sigField)-1:0] magB;
    logic swap;
    unpackedSrc bigOp;
    unpackedSrc smallOp;
    logic bigSign;
    logic effSub;
    expField expDiff;
    sigGrs smallExt;
    sigGrs smallShift;
    sigGrs shiftMask;
    logic lostBits;
    sigGrs smallAligned;
    logic [$bits(sigGrs):0] sum;
    logic [4:0] lzc;
    wideExp resExp;
    sigGrs normSig;
    logic anyNan;
    logic anySnan;
    logic infMinusInf;
    logic bothZero;
    logic zeroSum;
    logic nanRes;
    logic infRes;
    logic resSign;
    logic cmpEqual;
    logic cmpLess;
    alignedOp nextOp;

    assign younger = inBranch.taken && ($signed(inOp.sqN - inBranch.sqN) > 0);
    assign isArith = (inOp.opcode == FADD) || (inOp.opcode == FSUB);
    assign signB = inOp.b.sign ^ (inOp.opcode == FSUB);

    // order operands by magnitude
    assign magA = {inOp.a.exp, inOp.a.sig};
    assign magB = {inOp.b.exp, inOp.b.sig};
    assign swap = magB > magA;
    assign bigOp = swap ? inOp.b : inOp.a;
    assign smallOp = swap ? inOp.a : inOp.b;
    assign bigSign = swap ? signB : inOp.a.sign;
    assign effSub = inOp.a.sign ^ signB;
    assign expDiff = bigOp.exp - smallOp.exp;

    // bits pushed out on the right fold into sticky
    assign smallExt = {smallOp.sig, 3'b000};
    assign smallShift = smallExt >> expDiff;
    assign shiftMask = ~({$bits(sigGrs){1'b1}} << expDiff);
    assign lostBits = |(smallExt & shiftMask);
    assign smallAligned = {smallShift[26:1], smallShift[0] | lostBits};

    // big is never smaller, so the difference stays positive
    assign sum = effSub ? {1'b0, bigOp.sig, 3'b000} - {1'b0, smallAligned}
                        : {1'b0, bigOp.sig, 3'b000} + {1'b0, smallAligned};

    assign lzc = countLeadingZeros(sum[26:0]);

    always_comb begin
        if (sum[27]) begin
            normSig = {sum[27:2], sum[1] | sum[0]};
            resExp = wideExp'(bigOp.exp) + wideExp'(1);
        end else begin
            normSig = sum[26:0] << lzc;
            resExp = wideExp'(bigOp.exp) - wideExp'(lzc);
        end
    end

    assign anyNan = inOp.a.isQnan | inOp.a.isSnan | inOp.b.isQnan | inOp.b.isSnan;
    assign anySnan = inOp.a.isSnan | inOp.b.isSnan;
    assign infMinusInf = inOp.a.isInf & inOp.b.isInf & (inOp.a.sign != signB);
    assign bothZero = inOp.a.isZero & inOp.b.isZero;
    assign zeroSum = (sum == '0);
    assign nanRes = anyNan || infMinusInf;
    assign infRes = !nanRes && (inOp.a.isInf || inOp.b.isInf);

    // x - x gives +0 except under RDN
    always_comb begin
        if (infRes) begin
            resSign = inOp.a.isInf ? inOp.a.sign : signB;
        end else if (zeroSum && effSub) begin
            resSign = (inOp.rm == 3'd2);
        end else begin
            resSign = bigSign;
        end
    end

    // +0 and -0 compare equal
    assign cmpEqual = !anyNan &&
        (bothZero || ((inOp.a.sign == inOp.b.sign) && (magA == magB)));
    assign cmpLess = !anyNan && !bothZero &&
        ((inOp.a.sign && !inOp.b.sign) ||
         (!inOp.a.sign && !inOp.b.sign && (magA < magB)) ||
         (inOp.a.sign && inOp.b.sign && (magA > magB)));

    always_comb begin
        nextOp.valid = inOp.valid && !younger;
        nextOp.opcode = inOp.opcode;
        nextOp.srcA = inOp.srcA;
        nextOp.srcB = inOp.srcB;
        nextOp.sqN = inOp.sqN;
        nextOp.tagDst = inOp.tagDst;
        nextOp.sign = resSign;
        nextOp.exp = resExp;
        nextOp.sig = normSig;
        nextOp.exactZero = zeroSum;
        nextOp.infResult = infRes;
        nextOp.nanResult = nanRes;
        nextOp.invalid = isArith && (anySnan || infMinusInf);
        nextOp.lessThan = cmpLess;
        nextOp.equal = cmpEqual;
        // FLT and FLE signal on any NaN
        nextOp.cmpInvalid = ((inOp.opcode == FLT) || (inOp.opcode == FLE)) ? anyNan : anySnan;
        nextOp.rm = inOp.rm;
        nextOp.illegal = inOp.illegal;
    end

    always_ff @(posedge clk) begin
        outOp <= nextOp;
        if (!rstN) begin
            outOp.valid <= 1'b0;
        end
    end

    // normaliser leaves the hidden bit on top for any finite nonzero sum
    assert property (@(posedge clk) disable iff (!rstN)
        outOp.valid && ((outOp.opcode == FADD) || (outOp.opcode == FSUB)) &&
        !outOp.exactZero && !outOp.nanResult && !outOp.infResult |-> outOp.sig[26]);

endmodule

/* hdl/fpuRoundStage.sv */
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpuRoundStage (
    input  logic              clk,
    input  logic              rstN,
    input  fpuPkg::branchProv inBranch,
    input  fpuPkg::alignedOp  inOp,
    output fpuPkg::fpuResult  outResult
);
    import fpuPkg::*;

    function automatic logic isNanWord(input fpWord w);
        return (&w[`FPU_EXP_BITS+`FPU_MAN_BITS-1:`FPU_MAN_BITS]) &&
               (w[`FPU_MAN_BITS-1:0] != '0);
    endfunction

    logic younger;
    logic isArith;
    logic lsb;
    logic guardBit;
    logic stickyBit;
    logic inexact;
    logic roundUp;
    logic [`FPU_MAN_BITS+1:0] rounded;
    sigField mant;
    wideExp finalExp;
    logic overflow;
    logic underflow;
    logic overflowToInf;
    logic aNan;
    logic bNan;
    logic minChooseA;
    logic maxChooseA;
    logic nv;
    logic of;
    logic uf;
    logic nx;
    fpuResult nextRes;

    assign younger = inBranch.taken && ($signed(inOp.sqN - inBranch.sqN) > 0);
    assign isArith = (inOp.opcode == FADD) || (inOp.opcode == FSUB);

    assign lsb = inOp.sig[3];
    assign guardBit = inOp.sig[2];
    assign stickyBit = inOp.sig[1] | inOp.sig[0];
    assign inexact = guardBit | stickyBit;

    always_comb begin
        case (inOp.rm)
            3'd1: roundUp = 1'b0;
            3'd2: roundUp = inOp.sign && inexact;
            3'd3: roundUp = !inOp.sign && inexact;
            3'd4: roundUp = guardBit;
            // RNE, also for the dynamic encoding
            default: roundUp = guardBit && (stickyBit || lsb);
        endcase
    end

    assign rounded = {1'b0, inOp.sig[26:3]} + {{(`FPU_MAN_BITS+1){1'b0}}, roundUp};
    // carry out of rounding bumps the exponent
    assign mant = rounded[`FPU_MAN_BITS+1] ? rounded[`FPU_MAN_BITS+1:1] : rounded[`FPU_MAN_BITS:0];
    assign finalExp = inOp.exp + wideExp'(rounded[`FPU_MAN_BITS+1]);
    assign overflow = finalExp >= wideExp'(255);
    assign underflow = finalExp <= wideExp'(0);

    // directed modes may clamp to max finite instead
    always_comb begin
        case (inOp.rm)
            3'd1: overflowToInf = 1'b0;
            3'd2: overflowToInf = inOp.sign;
            3'd3: overflowToInf = !inOp.sign;
            default: overflowToInf = 1'b1;
        endcase
    end

    assign aNan = isNanWord(inOp.srcA);
    assign bNan = isNanWord(inOp.srcB);
    assign minChooseA = bNan || inOp.lessThan ||
        (inOp.equal && inOp.srcA[31] && !inOp.srcB[31]);
    assign maxChooseA = bNan || (!inOp.lessThan && !inOp.equal && !aNan) ||
        (inOp.equal && !inOp.srcA[31] && inOp.srcB[31]);

    always_comb begin
        nv = 1'b0;
        of = 1'b0;
        uf = 1'b0;
        nx = 1'b0;
        nextRes.valid = inOp.valid && !younger;
        nextRes.sqN = inOp.sqN;
        nextRes.tagDst = inOp.tagDst;
        case (inOp.opcode)
            FEQ: begin
                nextRes.result = {31'd0, inOp.equal};
                nv = inOp.cmpInvalid;
            end
            FLT: begin
                nextRes.result = {31'd0, inOp.lessThan};
                nv = inOp.cmpInvalid;
            end
            FLE: begin
                nextRes.result = {31'd0, inOp.lessThan || inOp.equal};
                nv = inOp.cmpInvalid;
            end
            FMIN, FMAX: begin
                if (aNan && bNan) begin
                    nextRes.result = `FPU_CANON_NAN;
                end else if ((inOp.opcode == FMIN) ? minChooseA : maxChooseA) begin
                    nextRes.result = inOp.srcA;
                end else begin
                    nextRes.result = inOp.srcB;
                end
                nv = inOp.cmpInvalid;
            end
            default: begin
                nv = inOp.invalid;
                if (inOp.nanResult) begin
                    nextRes.result = `FPU_CANON_NAN;
                end else if (inOp.infResult) begin
                    nextRes.result = {inOp.sign, {`FPU_EXP_BITS{1'b1}}, {`FPU_MAN_BITS{1'b0}}};
                end else if (inOp.exactZero) begin
                    nextRes.result = {inOp.sign, 31'd0};
                end else if (overflow) begin
                    of = 1'b1;
                    nx = 1'b1;
                    nextRes.result = overflowToInf ?
                        {inOp.sign, {`FPU_EXP_BITS{1'b1}}, {`FPU_MAN_BITS{1'b0}}} :
                        {inOp.sign, 8'hfe, {`FPU_MAN_BITS{1'b1}}};
                end else if (underflow) begin
                    // too small for a normal, flush
                    uf = 1'b1;
                    nx = 1'b1;
                    nextRes.result = {inOp.sign, 31'd0};
                end else begin
                    nx = inexact;
                    nextRes.result = {inOp.sign, finalExp[`FPU_EXP_BITS-1:0],
                                      mant[`FPU_MAN_BITS-1:0]};
                end
            end
        endcase
        // DZ cannot arise here, no divider
        if (inOp.illegal) begin
            nextRes.flags = ILLEGAL;
        end else if (nv) begin
            nextRes.flags = NV;
        end else if (of) begin
            nextRes.flags = OF;
        end else if (uf) begin
            nextRes.flags = UF;
        end else if (nx) begin
            nextRes.flags = NX;
        end else begin
            nextRes.flags = NONE;
        end
    end

    always_ff @(posedge clk) begin
        outResult <= nextRes;
        if (!rstN) begin
            outResult.valid <= 1'b0;
        end
    end

    // add/sub never leaks a NaN payload from its inputs
    assert property (@(posedge clk) disable iff (!rstN)
        inOp.valid && isArith |=>
        !isNanWord(outResult.result) || (outResult.result == `FPU_CANON_NAN));

endmodule

/* hdl/fpuPipe.sv */
`timescale 1ns/1ps

module fpuPipe (
    input  logic              clk,
    input  logic              rstN,
    input  logic              en,
    input  fpuPkg::branchProv inBranch,
    input  fpuPkg::fpuUop     inUop,
    input  fpuPkg::roundMode  roundingMode,
    output fpuPkg::fpuResult  outResult
);
    import fpuPkg::*;

    // stage registers
    unpackedOp unpacked;
    alignedOp  aligned;

    fpuUnpackStage unpackStage (
        .clk          (clk),
        .rstN         (rstN),
        .en           (en),
        .inBranch     (inBranch),
        .inUop        (inUop),
        .roundingMode (roundingMode),
        .outOp        (unpacked)
    );

    fpuAlignAddStage alignAddStage (
        .clk      (clk),
        .rstN     (rstN),
        .inBranch (inBranch),
        .inOp     (unpacked),
        .outOp    (aligned)
    );

    // results leave three edges after acceptance
    fpuRoundStage roundStage (
        .clk       (clk),
        .rstN      (rstN),
        .inBranch  (inBranch),
        .inOp      (aligned),
        .outResult (outResult)
    );

endmodule

/* testbench/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rstN
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // low across the first four rising edges, released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

/* testbench/fpuPipeTb.sv */
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpuPipeTb;
    import fpuPkg::*;

    typedef struct packed {
        logic      valid;
        logic      checkWord;
        fpWord     word;
        resultFlag flag;
        seqNum     sqN;
        regTag     tagDst;
    } expectedOut;

    localparam int testCount = 6;
    localparam int opsPerTest = 40;
    localparam int watchdogCycles = testCount * opsPerTest + 20;

    logic clk;
    logic rstN;
    logic en;
    branchProv inBranch;
    fpuUop inUop;
    roundMode roundingMode;
    fpuResult outResult;

    expectedOut cur;
    expectedOut expPipe [3];
    expectedOut due;
    logic [31:0] lfsr;
    seqNum nextSqN;
    int testsRun;
    int opsInTest;
    int totalOps;
    int validErrors = 0;
    int wordErrors = 0;
    int flagErrors = 0;
    int orderErrors = 0;
    int tagErrors = 0;

    clockGen clockSource (.clk(clk), .rstN(rstN));

    fpuPipe uut (
        .clk          (clk),
        .rstN         (rstN),
        .en           (en),
        .inBranch     (inBranch),
        .inUop        (inUop),
        .roundingMode (roundingMode),
        .outResult    (outResult)
    );

    function automatic int failures();
        return validErrors + wordErrors + flagErrors + orderErrors + tagErrors;
    endfunction

    // Galois form, one step per bit taken
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic isNan(input fpWord w);
        return (w[30:23] == 8'hff) && (w[22:0] != '0);
    endfunction

    function automatic logic isSignaling(input fpWord w);
        return isNan(w) && !w[22];
    endfunction

    // subnormals count as signed zero
    function automatic real toReal(input fpWord w);
        logic [10:0] de;
        de = {3'b000, w[30:23]} + 11'd896;
        if (w[30:23] == 8'd0) begin
            return $bitstoreal({w[31], 63'd0});
        end
        return $bitstoreal({w[31], de, w[22:0], 29'd0});
    endfunction

    // nearest-even narrowing of a double, inexact bit on top
    function automatic logic [32:0] narrowToSingle(input real r);
        logic [63:0] d;
        logic [24:0] m;
        logic [10:0] e;
        logic up;
        d = $realtobits(r);
        if (d[62:0] == '0) begin
            return {1'b0, d[63], 31'd0};
        end
        up = d[28] && ((d[27:0] != '0) || d[29]);
        m = {2'b01, d[51:29]} + {24'd0, up};
        e = d[62:52] - 11'd896;
        if (m[24]) begin
            m = m >> 1;
            e = e + 11'd1;
        end
        return {d[28:0] != '0, d[63], e[7:0], m[22:0]};
    endfunction

    function automatic expectedOut predict(input fpuOpcode op, input fpWord a, input fpWord b);
        expectedOut e;
        logic anyNan;
        logic anySnan;
        real ra;
        real rb;
        logic [32:0] n;
        anyNan = isNan(a) || isNan(b);
        anySnan = isSignaling(a) || isSignaling(b);
        ra = toReal(a);
        rb = toReal(b);
        e = '0;
        e.valid = 1'b1;
        e.checkWord = 1'b1;
        case (op)
            FADD, FSUB: begin
                n = narrowToSingle((op == FSUB) ? ra - rb : ra + rb);
                e.word = n[31:0];
                e.flag = n[32] ? NX : NONE;
            end
            FEQ: begin
                e.word = {31'd0, !anyNan && (ra == rb)};
                e.flag = anySnan ? NV : NONE;
            end
            FLT: begin
                e.word = {31'd0, !anyNan && (ra < rb)};
                e.flag = anyNan ? NV : NONE;
            end
            FLE: begin
                e.word = {31'd0, !anyNan && (ra <= rb)};
                e.flag = anyNan ? NV : NONE;
            end
            default: begin
                if (anyNan && isNan(a) && isNan(b))
                    e.word = `FPU_CANON_NAN;
                else if (isNan(a))
                    e.word = b;
                else if (isNan(b))
                    e.word = a;
                // -0 sits below +0
                else if (ra == rb)
                    e.word = ((op == FMIN) == a[31]) ? a : b;
                else
                    e.word = ((ra < rb) == (op == FMIN)) ? a : b;
                e.flag = anySnan ? NV : NONE;
            end
        endcase
        return e;
    endfunction

    function automatic expectedOut fixedExpect(input fpWord w, input resultFlag f,
                                               input logic checkWord);
        expectedOut e;
        e = '0;
        e.valid = 1'b1;
        e.checkWord = checkWord;
        e.word = w;
        e.flag = f;
        return e;
    endfunction

    // normal operands with exponents less than 20 apart
    task automatic randomPair(output fpWord a, output fpWord b);
        logic [31:0] r;
        logic [31:0] fa;
        logic [31:0] fb;
        logic [7:0] ea;
        logic [7:0] eb;
        r = takeBits(10);
        ea = 8'd100 + {2'b00, r[5:0]};
        eb = ea + {4'd0, r[9:6]} - 8'd8;
        fa = takeBits(24);
        fb = takeBits(24);
        a = {fa[23], ea, fa[22:0]};
        b = {fb[23], eb, fb[22:0]};
    endtask

    task automatic pickOperands(input int variant, output fpWord a, output fpWord b);
        randomPair(a, b);
        case (variant)
            1: b = a;
            2: begin
                a = {a[31], 31'd0};
                b = {!a[31], 31'd0};
            end
            3: a = 32'h7fc00001;
            4: b = 32'h7f800011;
            5: begin
                a = 32'h7fc00001;
                b = 32'h7f800011;
            end
            default: ;
        endcase
    endtask

    task automatic issue(input fpuOpcode op, input fpWord a, input fpWord b,
                         input roundMode rm, input logic enable, input expectedOut e);
        @(negedge clk);
        en = enable;
        inUop.valid = 1'b1;
        inUop.opcode = op;
        inUop.srcA = a;
        inUop.srcB = b;
        inUop.sqN = nextSqN;
        // tag differs from the sequence bits
        inUop.tagDst = nextSqN[5:0] ^ 6'h2a;
        roundingMode = rm;
        cur = e;
        cur.sqN = nextSqN;
        cur.tagDst = inUop.tagDst;
        nextSqN = nextSqN + 7'd1;
        opsInTest++;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            inUop.valid = 1'b0;
            cur = '0;
        end
    endtask

    // latency is three edges, so four idle cycles drain the pipe
    task automatic finishTest(input string name, input int errorsBefore);
        idle(4);
        testsRun++;
        totalOps += opsInTest;
        $display("%s: %0d ops, %0d errors", name, opsInTest, failures() - errorsBefore);
        opsInTest = 0;
    endtask

    task automatic runAddSub();
        int errorsBefore;
        fpWord a;
        fpWord b;
        fpuOpcode op;
        errorsBefore = failures();
        for (int i = 0; i < 32; i++) begin
            randomPair(a, b);
            if (i % 8 == 7)
                b = a;
            op = (i % 2 == 0) ? FADD : FSUB;
            issue(op, a, b, 3'd0, 1'b1, predict(op, a, b));
        end
        finishTest("add/sub RNE", errorsBefore);
    endtask

    task automatic runCompares();
        int errorsBefore;
        fpWord a;
        fpWord b;
        fpuOpcode op;
        errorsBefore = failures();
        for (int i = 0; i < 24; i++) begin
            pickOperands((i / 3) % 5, a, b);
            op = (i % 3 == 0) ? FEQ : ((i % 3 == 1) ? FLT : FLE);
            issue(op, a, b, 3'd0, 1'b1, predict(op, a, b));
        end
        finishTest("compares", errorsBefore);
    endtask

    task automatic runMinMax();
        int errorsBefore;
        fpWord a;
        fpWord b;
        fpuOpcode op;
        errorsBefore = failures();
        for (int i = 0; i < 20; i++) begin
            pickOperands((i / 2) % 6, a, b);
            op = (i % 2 == 0) ? FMIN : FMAX;
            issue(op, a, b, 3'd0, 1'b1, predict(op, a, b));
        end
        finishTest("min/max", errorsBefore);
    endtask

    task automatic runSpecials();
        int errorsBefore;
        errorsBefore = failures();
        issue(FSUB, 32'h7f800000, 32'h7f800000, 3'd0, 1'b1,
              fixedExpect(`FPU_CANON_NAN, NV, 1'b1));
        issue(FADD, 32'h7f800000, 32'hff800000, 3'd0, 1'b1,
              fixedExpect(`FPU_CANON_NAN, NV, 1'b1));
        issue(FADD, 32'h7f7fffff, 32'h7f7fffff, 3'd0, 1'b1,
              fixedExpect(32'h7f800000, OF, 1'b1));
        // RTZ clamps to the largest finite value
        issue(FADD, 32'h7f7fffff, 32'h7f7fffff, 3'd1, 1'b1,
              fixedExpect(32'h7f7fffff, OF, 1'b1));
        finishTest("special sums", errorsBefore);
    endtask

    task automatic runReservedMode();
        int errorsBefore;
        fpWord a;
        fpWord b;
        errorsBefore = failures();
        randomPair(a, b);
        issue(FADD, a, b, 3'd5, 1'b1, fixedExpect('0, ILLEGAL, 1'b0));
        randomPair(a, b);
        issue(FSUB, a, b, 3'd6, 1'b1, fixedExpect('0, ILLEGAL, 1'b0));
        // compares ignore the rounding mode
        pickOperands(1, a, b);
        issue(FEQ, a, b, 3'd5, 1'b1, predict(FEQ, a, b));
        finishTest("reserved rounding mode", errorsBefore);
    endtask

    task automatic runFlush();
        int errorsBefore;
        fpWord a;
        fpWord b;
        seqNum branchSq;
        expectedOut e;
        errorsBefore = failures();
        branchSq = nextSqN + 7'd2;
        for (int i = 0; i < 6; i++) begin
            randomPair(a, b);
            e = predict(FADD, a, b);
            // younger ops are still inside the pipe when the branch resolves
            e.valid = (i <= 2);
            issue(FADD, a, b, 3'd0, 1'b1, e);
            if (i == 5) begin
                inBranch.taken = 1'b1;
                inBranch.sqN = branchSq;
            end
        end
        randomPair(a, b);
        e = predict(FSUB, a, b);
        e.valid = 1'b0;
        issue(FSUB, a, b, 3'd0, 1'b0, e);
        inBranch = '0;
        for (int i = 0; i < 3; i++) begin
            randomPair(a, b);
            issue(FSUB, a, b, 3'd0, 1'b1, predict(FSUB, a, b));
        end
        finishTest("flush", errorsBefore);
    endtask

    // expected results walk alongside the three pipeline registers
    always_ff @(posedge clk) begin
        if (!rstN) begin
            expPipe[0] <= '0;
            expPipe[1] <= '0;
            expPipe[2] <= '0;
        end else begin
            expPipe[0] <= cur;
            expPipe[1] <= expPipe[0];
            expPipe[2] <= expPipe[1];
        end
    end

    assign due = expPipe[2];

    assert property (@(posedge clk) disable iff (!rstN) outResult.valid == due.valid)
    else begin
        validErrors++;
        $display("[ERROR] %0t outResult.valid got %b expected %b", $time,
                 $sampled(outResult.valid), $sampled(due.valid));
    end

    assert property (@(posedge clk) disable iff (!rstN)
        due.valid && due.checkWord |-> outResult.result == due.word)
    else begin
        wordErrors++;
        $display("[ERROR] %0t outResult.result got %h expected %h", $time,
                 $sampled(outResult.result), $sampled(due.word));
    end

    assert property (@(posedge clk) disable iff (!rstN)
        due.valid |-> outResult.flags == due.flag)
    else begin
        flagErrors++;
        $display("[ERROR] %0t outResult.flags got %0d expected %0d", $time,
                 $sampled(outResult.flags), $sampled(due.flag));
    end

    // sequence numbers also prove in-order delivery
    assert property (@(posedge clk) disable iff (!rstN)
        due.valid |-> outResult.sqN == due.sqN)
    else begin
        orderErrors++;
        $display("[ERROR] %0t outResult.sqN got %0d expected %0d", $time,
                 $sampled(outResult.sqN), $sampled(due.sqN));
    end

    assert property (@(posedge clk) disable iff (!rstN)
        due.valid |-> outResult.tagDst == due.tagDst)
    else begin
        tagErrors++;
        $display("[ERROR] %0t outResult.tagDst got %0d expected %0d", $time,
                 $sampled(outResult.tagDst), $sampled(due.tagDst));
    end

    initial begin
        #(watchdogCycles * 100);
        $display("watchdog expired after %0d cycles, tests did not complete", watchdogCycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        lfsr = 32'hd8f461f9;
        en = 1'b0;
        inUop = '0;
        inBranch = '0;
        roundingMode = 3'd0;
        cur = '0;
        nextSqN = '0;
        testsRun = 0;
        opsInTest = 0;
        totalOps = 0;
        @(posedge rstN);
        runAddSub();
        runCompares();
        runMinMax();
        runSpecials();
        runReservedMode();
        runFlush();
        $display("tests run %0d, ops issued %0d, failed checks %0d",
                 testsRun, totalOps, failures());
        if (failures() == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+hdl
hdl/fpuPkg.sv
hdl/fpuUnpackStage.sv
hdl/fpuAlignAddStage.sv
hdl/fpuRoundStage.sv
hdl/fpuPipe.sv
testbench/clockGen.sv
testbench/fpuPipeTb.sv

/* Makefile */
SIM      := verilator
TOP      := fpuPipeTb
FLIST    := flist.f
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
BUILDDIR := obj_dir
LOG      := sim.log

BIN      := $(BUILDDIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FLIST))
HEADERS  := $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILDDIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
